/* hw/axil_map_pkg.sv */
package axil_map_pkg;

  ////////////////////////////////////////////////////////////
  // Bus and memory widths
  ////////////////////////////////////////////////////////////

  localparam int ADDR_W    = 12;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int NUM_BANKS = 4;
  localparam int BANK_AW   = 6;

  // Address field widths shared by both address views
  localparam int REGION_W  = 2;
  localparam int BANK_SW   = $clog2(NUM_BANKS);
  localparam int BYTE_W    = 2;
  localparam int REG_IDX_W = ADDR_W - REGION_W - BYTE_W;

  ////////////////////////////////////////////////////////////
  // Address map and response codes
  ////////////////////////////////////////////////////////////

  // Region codes 2 and 3 are left unmapped
  localparam logic [REGION_W-1:0] REGION_REGS  = 2'd0;
  localparam logic [REGION_W-1:0] REGION_BANKS = 2'd1;

  localparam logic [REG_IDX_W-1:0] REG_STATUS = 8'd0;
  localparam logic [REG_IDX_W-1:0] REG_CONFIG = 8'd1;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  ////////////////////////////////////////////////////////////
  // Address views and local transfer types
  ////////////////////////////////////////////////////////////

  // Bank view of a byte address
  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [BANK_SW-1:0]  bank;
    logic [BANK_AW-1:0]  word;
    logic [BYTE_W-1:0]   byte_off;
  } bank_addr_t;

  // Register view of the same byte address
  typedef struct packed {
    logic [REGION_W-1:0]  region;
    logic [REG_IDX_W-1:0] idx;
    logic [BYTE_W-1:0]    byte_off;
  } reg_addr_t;

  typedef union packed {
    bank_addr_t bank;
    reg_addr_t  regs;
  } axil_addr_u;

  // Request handed from the front end to one target
  typedef struct packed {
    logic              write;
    axil_addr_u        addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } loc_req_t;

  // Response returned by a target
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        resp;
  } loc_rsp_t;

  // Pins of one external BRAM bank
  typedef struct packed {
    logic               en;
    logic [STRB_W-1:0]  we;
    logic [BANK_AW-1:0] addr;
    logic [DATA_W-1:0]  wdata;
  } bram_req_t;

endpackage

/* hw/axil_front.sv */
`timescale 1ns/100ps

module axil_front (
  input  logic                              aclk,
  input  logic                              aresetn,
  // Write address channel
  input  logic [axil_map_pkg::ADDR_W-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  // Write data channel
  input  logic [axil_map_pkg::DATA_W-1:0]   wdata,
  input  logic [axil_map_pkg::STRB_W-1:0]   wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  // Write response channel
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  // Read address channel
  input  logic [axil_map_pkg::ADDR_W-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  // Read data channel
  output logic [axil_map_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  // Local side
  input  axil_map_pkg::loc_rsp_t            rsp,
  output axil_map_pkg::loc_req_t            req,
  output logic                              req_valid
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_HOLD
  } state_e;

  state_e                 state;
  state_e                 state_nxt;
  logic                   rdy_q;
  logic                   wr_acc;
  logic                   rd_acc;
  logic                   rsp_take;
  axil_map_pkg::loc_req_t req_q;

  ////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////

  // Ready only in idle, low on the cycle out of reset
  // AW and W are taken together, each ready drops if its partner is missing
  assign awready = rdy_q && (wvalid || !awvalid);
  assign wready  = rdy_q && (awvalid || !wvalid);
  // Write pair wins over a read in the same cycle
  assign arready = rdy_q && !(awvalid && wvalid);

  assign wr_acc = rdy_q && awvalid && wvalid;
  assign rd_acc = arready && arvalid;

  // Target answers while the request is out or pending
  assign rsp_take = rsp.valid && ((state == ST_ISSUE) || (state == ST_WAIT));

  ////////////////////////////////////////////////////////////
  // Channel FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (wr_acc || rd_acc) begin
          state_nxt = ST_ISSUE;
        end
      end
      // Fast targets answer in the request cycle, bank reads one later
      ST_ISSUE, ST_WAIT: begin
        state_nxt = rsp.valid ? ST_HOLD : ST_WAIT;
      end
      ST_HOLD: begin
        if ((bvalid && bready) || (rvalid && rready)) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state <= ST_IDLE;
      rdy_q <= 1'b0;
    end else begin
      state <= state_nxt;
      rdy_q <= (state_nxt == ST_IDLE);
    end
  end

  // Captured transaction
  always_ff @(posedge aclk) begin
    if (wr_acc) begin
      req_q.write <= 1'b1;
      req_q.addr  <= awaddr;
      req_q.wdata <= wdata;
      req_q.wstrb <= wstrb;
    end else if (rd_acc) begin
      req_q.write <= 1'b0;
      req_q.addr  <= araddr;
      req_q.wdata <= '0;
      req_q.wstrb <= '0;
    end
  end

  assign req       = req_q;
  // One-cycle strobe the cycle after acceptance
  assign req_valid = (state == ST_ISSUE);

  ////////////////////////////////////////////////////////////
  // Response holding
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (rsp_take && req_q.write) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rsp_take && !req_q.write) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Payload stays put until the master takes it
  always_ff @(posedge aclk) begin
    if (rsp_take) begin
      if (req_q.write) begin
        bresp <= rsp.resp;
      end else begin
        rdata <= rsp.rdata;
        rresp <= rsp.resp;
      end
    end
  end

endmodule

/* hw/axil_addr_decode.sv */
`timescale 1ns/100ps

module axil_addr_decode (
  input  axil_map_pkg::loc_req_t              req,
  input  logic                                req_valid,
  output logic                                reg_sel,
  output logic [axil_map_pkg::NUM_BANKS-1:0]  bank_sel,
  output axil_map_pkg::loc_rsp_t              dec_rsp
);

  logic [axil_map_pkg::REGION_W-1:0] region;
  logic [axil_map_pkg::BANK_SW-1:0]  bank_idx;

  // Region sits in the same bits in both views
  assign region   = req.addr.regs.region;
  assign bank_idx = req.addr.bank.bank;

  ////////////////////////////////////////////////////////////
  // Target select
  ////////////////////////////////////////////////////////////

  always_comb begin
    reg_sel  = 1'b0;
    bank_sel = '0;
    dec_rsp  = '0;
    if (req_valid) begin
      case (region)
        axil_map_pkg::REGION_REGS: begin
          reg_sel = 1'b1;
        end
        axil_map_pkg::REGION_BANKS: begin
          // Bank field of the bank view picks one port
          bank_sel[bank_idx] = 1'b1;
        end
        default: begin
          // Nobody lives here, answer at once with zero data
          dec_rsp.valid = 1'b1;
          dec_rsp.rdata = '0;
          dec_rsp.resp  = axil_map_pkg::RESP_DECERR;
        end
      endcase
    end
  end

endmodule

/* hw/bank_port.sv */
`timescale 1ns/100ps

module bank_port (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             sel,
  input  axil_map_pkg::loc_req_t           req,
  input  logic [axil_map_pkg::DATA_W-1:0]  bram_rdata,
  output axil_map_pkg::bram_req_t          bram,
  output axil_map_pkg::loc_rsp_t           rsp
);

  logic wr_hit;
  logic rd_hit;
  logic rd_pend;

  assign wr_hit = sel && req.write;
  assign rd_hit = sel && !req.write;

  ////////////////////////////////////////////////////////////
  // BRAM pins
  ////////////////////////////////////////////////////////////

  always_comb begin
    bram.en    = sel;
    // Strobes become byte write enables, writes only
    bram.we    = wr_hit ? req.wstrb : '0;
    // Word index of the bank view, byte bits dropped
    bram.addr  = req.addr.bank.word;
    bram.wdata = req.wdata;
  end

  // Read data shows up one cycle after the enable
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= rd_hit;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Write ack in the request cycle, read data a cycle later
    rsp.valid = wr_hit || rd_pend;
    rsp.rdata = rd_pend ? bram_rdata : '0;
    rsp.resp  = axil_map_pkg::RESP_OKAY;
  end

endmodule

/* hw/ctrl_regs.sv */
`timescale 1ns/100ps

module ctrl_regs (
  input  logic                             aclk,
  input  logic                             aresetn,
  input  logic                             sel,
  input  axil_map_pkg::loc_req_t           req,
  input  logic                             ap_done,
  output axil_map_pkg::loc_rsp_t           rsp,
  output logic [axil_map_pkg::DATA_W-1:0]  cfg_data
);

  logic                                 done_q;
  logic [axil_map_pkg::DATA_W-1:0]      cfg_q;
  logic [axil_map_pkg::REG_IDX_W-1:0]   idx;
  logic                                 hit_status;
  logic                                 hit_cfg;
  logic                                 wr_hit;
  logic                                 done_clr;

  assign idx        = req.addr.regs.idx;
  assign hit_status = (idx == axil_map_pkg::REG_STATUS);
  assign hit_cfg    = (idx == axil_map_pkg::REG_CONFIG);
  assign wr_hit     = sel && req.write;

  // Write one to bit 0 with lane 0 enabled
  assign done_clr = wr_hit && hit_status && req.wstrb[0] && req.wdata[0];

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      done_q <= 1'b0;
    end else if (ap_done) begin
      // A fresh done pulse beats a clear in the same cycle
      done_q <= 1'b1;
    end else if (done_clr) begin
      done_q <= 1'b0;
    end
  end

  // Config word, one byte lane per strobe
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      cfg_q <= '0;
    end else if (wr_hit && hit_cfg) begin
      for (int i = 0; i < axil_map_pkg::STRB_W; i++) begin
        if (req.wstrb[i]) begin
          cfg_q[8*i +: 8] <= req.wdata[8*i +: 8];
        end
      end
    end
  end

  assign cfg_data = cfg_q;

  ////////////////////////////////////////////////////////////
  // Response in the request cycle
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp.valid = sel;
    rsp.rdata = '0;
    rsp.resp  = axil_map_pkg::RESP_SLVERR;
    if (hit_status) begin
      rsp.resp = axil_map_pkg::RESP_OKAY;
      if (!req.write) begin
        rsp.rdata[0] = done_q;
      end
    end else if (hit_cfg) begin
      rsp.resp = axil_map_pkg::RESP_OKAY;
      if (!req.write) begin
        rsp.rdata = cfg_q;
      end
    end
  end

endmodule

/* hw/rsp_collect.sv */
`timescale 1ns/100ps

module rsp_collect (
  input  axil_map_pkg::loc_rsp_t                              reg_rsp,
  input  axil_map_pkg::loc_rsp_t [axil_map_pkg::NUM_BANKS-1:0] bank_rsp,
  input  axil_map_pkg::loc_rsp_t                              dec_rsp,
  output axil_map_pkg::loc_rsp_t                              rsp
);

  localparam int RSP_W = $bits(axil_map_pkg::loc_rsp_t);

  logic [RSP_W-1:0] merged;

  ////////////////////////////////////////////////////////////
  // Gated OR merge
  ////////////////////////////////////////////////////////////

  // At most one source is valid per request
  // Each source is masked by its own valid before the OR
  always_comb begin
    merged = {RSP_W{reg_rsp.valid}} & reg_rsp;
    for (int b = 0; b < axil_map_pkg::NUM_BANKS; b++) begin
      merged = merged | ({RSP_W{bank_rsp[b].valid}} & bank_rsp[b]);
    end
    // Decoder only speaks for unmapped regions
    merged = merged | ({RSP_W{dec_rsp.valid}} & dec_rsp);
  end

  assign rsp = merged;

endmodule

/* hw/axil_bram_subsys.sv */
`timescale 1ns/100ps

module axil_bram_subsys (
  input  logic                                                  aclk,
  input  logic                                                  aresetn,
  // AXI4-Lite slave
  input  logic [axil_map_pkg::ADDR_W-1:0]                       awaddr,
  input  logic                                                  awvalid,
  output logic                                                  awready,
  input  logic [axil_map_pkg::DATA_W-1:0]                       wdata,
  input  logic [axil_map_pkg::STRB_W-1:0]                       wstrb,
  input  logic                                                  wvalid,
  output logic                                                  wready,
  output logic [1:0]                                            bresp,
  output logic                                                  bvalid,
  input  logic                                                  bready,
  input  logic [axil_map_pkg::ADDR_W-1:0]                       araddr,
  input  logic                                                  arvalid,
  output logic                                                  arready,
  output logic [axil_map_pkg::DATA_W-1:0]                       rdata,
  output logic [1:0]                                            rresp,
  output logic                                                  rvalid,
  input  logic                                                  rready,
  // BRAM banks
  output axil_map_pkg::bram_req_t [axil_map_pkg::NUM_BANKS-1:0] bram,
  input  logic [axil_map_pkg::NUM_BANKS-1:0][axil_map_pkg::DATA_W-1:0] bram_rdata,
  // System side
  input  logic                                                  ap_done,
  output logic [axil_map_pkg::DATA_W-1:0]                       cfg_data
);

  axil_map_pkg::loc_req_t                              req;
  logic                                                req_valid;
  logic                                                reg_sel;
  logic [axil_map_pkg::NUM_BANKS-1:0]                  bank_sel;
  axil_map_pkg::loc_rsp_t                              dec_rsp;
  axil_map_pkg::loc_rsp_t                              reg_rsp;
  axil_map_pkg::loc_rsp_t [axil_map_pkg::NUM_BANKS-1:0] bank_rsp;
  axil_map_pkg::loc_rsp_t                              rsp;

  ////////////////////////////////////////////////////////////
  // Front end and routing
  ////////////////////////////////////////////////////////////

  axil_front u_front (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .rsp       (rsp),
    .req       (req),
    .req_valid (req_valid)
  );

  axil_addr_decode u_decode (
    .req       (req),
    .req_valid (req_valid),
    .reg_sel   (reg_sel),
    .bank_sel  (bank_sel),
    .dec_rsp   (dec_rsp)
  );

  ////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////

  ctrl_regs u_regs (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .sel      (reg_sel),
    .req      (req),
    .ap_done  (ap_done),
    .rsp      (reg_rsp),
    .cfg_data (cfg_data)
  );

  // One port per external bank, all sharing the request
  for (genvar b = 0; b < axil_map_pkg::NUM_BANKS; b++) begin : g_bank
    bank_port u_bank (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .sel        (bank_sel[b]),
      .req        (req),
      .bram_rdata (bram_rdata[b]),
      .bram       (bram[b]),
      .rsp        (bank_rsp[b])
    );
  end

  // Back to the front end as a single response
  rsp_collect u_collect (
    .reg_rsp  (reg_rsp),
    .bank_rsp (bank_rsp),
    .dec_rsp  (dec_rsp),
    .rsp      (rsp)
  );

endmodule

/* verif/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

////////////////////////////////////////////////////////////
// Typed compare tasks
////////////////////////////////////////////////////////////

task automatic check_data(input string name,
                          input logic [axil_map_pkg::DATA_W-1:0] exp,
                          input logic [axil_map_pkg::DATA_W-1:0] act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end_with_failure();
  end
endtask

task automatic check_resp(input string name,
                          input logic [1:0] exp,
                          input logic [1:0] act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
    end_with_failure();
  end
endtask

task automatic check_cfg(input string name,
                         input logic [axil_map_pkg::DATA_W-1:0] exp,
                         input logic [axil_map_pkg::DATA_W-1:0] act);
  if (act !== exp) begin
    $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end_with_failure();
  end
endtask

////////////////////////////////////////////////////////////
// AXI4-Lite master
////////////////////////////////////////////////////////////

// Entered and left 1 ns after a rising edge
// Ready is looked at on the falling edge where it has settled
task automatic axi_write(input logic [axil_map_pkg::ADDR_W-1:0] addr,
                         input logic [axil_map_pkg::DATA_W-1:0] data,
                         input logic [axil_map_pkg::STRB_W-1:0] strb,
                         output logic [1:0] resp);
  int n;
  int s;
  int stall;
  logic [1:0] held;
  // Address and data go out together
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = strb;
  wvalid  = 1'b1;
  n = 0;
  @(negedge aclk);
  while (!(awready && wready)) begin
    if (n == TIMEOUT) begin
      $display("Timeout: write address and data were never accepted at %0t", $time);
      end_with_failure();
    end
    n++;
    @(negedge aclk);
  end
  @(posedge aclk);
  #1;
  awvalid = 1'b0;
  wvalid  = 1'b0;
  n = 0;
  @(negedge aclk);
  while (!bvalid) begin
    if (n == TIMEOUT) begin
      $display("Timeout: no write response arrived at %0t", $time);
      end_with_failure();
    end
    n++;
    @(negedge aclk);
  end
  // Hold bready low a few cycles, response must sit still
  held  = bresp;
  stall = $urandom_range(0, 3);
  for (s = 0; s <= stall + 1; s++) begin
    if (!bvalid || bresp !== held) begin
      $display("Write response changed before bready at %0t", $time);
      end_with_failure();
    end
    if (awready || wready || arready) begin
      $display("New transaction accepted while a write response was pending at %0t", $time);
      end_with_failure();
    end
    if (s <= stall) begin
      @(posedge aclk);
      #1;
      bready = (s == stall);
      @(negedge aclk);
    end
  end
  @(posedge aclk);
  #1;
  bready = 1'b0;
  resp   = held;
endtask

task automatic axi_read(input logic [axil_map_pkg::ADDR_W-1:0] addr,
                        output logic [axil_map_pkg::DATA_W-1:0] data,
                        output logic [1:0] resp);
  int n;
  int s;
  int stall;
  logic [axil_map_pkg::DATA_W-1:0] held_data;
  logic [1:0] held_resp;
  araddr  = addr;
  arvalid = 1'b1;
  n = 0;
  @(negedge aclk);
  while (!arready) begin
    if (n == TIMEOUT) begin
      $display("Timeout: read address was never accepted at %0t", $time);
      end_with_failure();
    end
    n++;
    @(negedge aclk);
  end
  @(posedge aclk);
  #1;
  arvalid = 1'b0;
  n = 0;
  @(negedge aclk);
  while (!rvalid) begin
    if (n == TIMEOUT) begin
      $display("Timeout: no read data arrived at %0t", $time);
      end_with_failure();
    end
    n++;
    @(negedge aclk);
  end
  // Same back-pressure on the read side
  held_data = rdata;
  held_resp = rresp;
  stall     = $urandom_range(0, 3);
  for (s = 0; s <= stall + 1; s++) begin
    if (!rvalid || rdata !== held_data || rresp !== held_resp) begin
      $display("Read data changed before rready at %0t", $time);
      end_with_failure();
    end
    if (arready || awready || wready) begin
      $display("New transaction accepted while read data was pending at %0t", $time);
      end_with_failure();
    end
    if (s <= stall) begin
      @(posedge aclk);
      #1;
      rready = (s == stall);
      @(negedge aclk);
    end
  end
  @(posedge aclk);
  #1;
  rready = 1'b0;
  data   = held_data;
  resp   = held_resp;
endtask

`endif

/* verif/tb_axil_bram_subsys.sv */
`timescale 1ns/100ps

module tb_axil_bram_subsys;

  localparam int NB      = axil_map_pkg::NUM_BANKS;
  localparam int DW      = axil_map_pkg::DATA_W;
  localparam int WORDS   = 1 << axil_map_pkg::BANK_AW;
  localparam int TIMEOUT = 32;

  logic                                   aclk;
  logic                                   aresetn;
  logic [axil_map_pkg::ADDR_W-1:0]        awaddr;
  logic                                   awvalid;
  logic                                   awready;
  logic [DW-1:0]                          wdata;
  logic [axil_map_pkg::STRB_W-1:0]        wstrb;
  logic                                   wvalid;
  logic                                   wready;
  logic [1:0]                             bresp;
  logic                                   bvalid;
  logic                                   bready;
  logic [axil_map_pkg::ADDR_W-1:0]        araddr;
  logic                                   arvalid;
  logic                                   arready;
  logic [DW-1:0]                          rdata;
  logic [1:0]                             rresp;
  logic                                   rvalid;
  logic                                   rready;
  axil_map_pkg::bram_req_t [NB-1:0]       bram;
  logic [NB-1:0][DW-1:0]                  bram_rdata;
  logic                                   ap_done;
  logic [DW-1:0]                          cfg_data;

  // Bank contents behind the BRAM pins
  logic [DW-1:0] bank_mem [NB][WORDS];
  // Expected state
  logic [DW-1:0] ref_mem [NB][WORDS];
  logic [DW-1:0] ref_cfg;
  logic          ref_done;

  axil_bram_subsys UUT (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .bram       (bram),
    .bram_rdata (bram_rdata),
    .ap_done    (ap_done),
    .cfg_data   (cfg_data)
  );

  always #2 aclk = ~aclk;

  ////////////////////////////////////////////////////////////
  // BRAM bank models with registered read
  ////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    for (int b = 0; b < NB; b++) begin
      if (bram[b].en) begin
        for (int i = 0; i < axil_map_pkg::STRB_W; i++) begin
          if (bram[b].we[i]) begin
            bank_mem[b][bram[b].addr][8*i +: 8] <= bram[b].wdata[8*i +: 8];
          end
        end
        bram_rdata[b] <= bank_mem[b][bram[b].addr];
      end
    end
  end

  task automatic end_with_failure();
    $display("Test failed");
    $fatal(1, "Stopping at the first error");
  endtask

  `include "tb_axil_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////////////////////////

  // Start pattern spread over bank and word
  function automatic logic [DW-1:0] fill_word(input int b, input int w);
    int lin;
    lin = b * WORDS + w + 1;
    return (lin * 32'h9e37_79b9) ^ (lin << 20);
  endfunction

  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                input logic [DW-1:0] data,
                                                input logic [3:0] strb);
    logic [DW-1:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [axil_map_pkg::ADDR_W-1:0] bank_addr(input int b, input int w,
                                                               input int off);
    axil_map_pkg::axil_addr_u a;
    a.bank.region   = axil_map_pkg::REGION_BANKS;
    a.bank.bank     = b;
    a.bank.word     = w;
    a.bank.byte_off = off;
    return a;
  endfunction

  function automatic logic [axil_map_pkg::ADDR_W-1:0] reg_addr(input int idx, input int off);
    axil_map_pkg::axil_addr_u a;
    a.regs.region   = axil_map_pkg::REGION_REGS;
    a.regs.idx      = idx;
    a.regs.byte_off = off;
    return a;
  endfunction

  task automatic write_expect(input logic [axil_map_pkg::ADDR_W-1:0] addr,
                              input logic [DW-1:0] data, input logic [3:0] strb,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    check_resp("bresp", exp_resp, resp);
  endtask

  task automatic read_expect(input logic [axil_map_pkg::ADDR_W-1:0] addr,
                             input logic [DW-1:0] exp_data, input logic [1:0] exp_resp);
    logic [DW-1:0] data;
    logic [1:0]    resp;
    axi_read(addr, data, resp);
    check_resp("rresp", exp_resp, resp);
    check_data("rdata", exp_data, data);
  endtask

  task automatic expect_status();
    read_expect(reg_addr(axil_map_pkg::REG_STATUS, 0), {{(DW-1){1'b0}}, ref_done},
                axil_map_pkg::RESP_OKAY);
  endtask

  ////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    int n;
    n = 0;
    @(negedge aclk);
    while (!(arready && awready && wready)) begin
      if (n == TIMEOUT) begin
        $display("Timeout: front end never became ready after reset");
        end_with_failure();
      end
      n++;
      @(negedge aclk);
    end
    if (bvalid || rvalid) begin
      $display("A response valid is high with no transaction issued");
      end_with_failure();
    end
    for (int b = 0; b < NB; b++) begin
      if (bram[b].en || bram[b].we != '0) begin
        $display("BRAM bank %0d is enabled while idle", b);
        end_with_failure();
      end
    end
    check_cfg("cfg_data", '0, cfg_data);
    @(posedge aclk);
    #1;
  endtask

  // Random writes with random strobes mixed with reads
  task automatic run_bank_traffic(input int count);
    int            b;
    int            w;
    logic [DW-1:0] data;
    logic [3:0]    strb;
    for (int i = 0; i < count; i++) begin
      b = $urandom_range(0, NB - 1);
      w = $urandom_range(0, WORDS - 1);
      if ($urandom_range(0, 1)) begin
        data = $urandom;
        strb = $urandom_range(0, 15);
        write_expect(bank_addr(b, w, $urandom_range(0, 3)), data, strb,
                     axil_map_pkg::RESP_OKAY);
        ref_mem[b][w] = merge_bytes(ref_mem[b][w], data, strb);
      end else begin
        read_expect(bank_addr(b, w, $urandom_range(0, 3)), ref_mem[b][w],
                    axil_map_pkg::RESP_OKAY);
      end
    end
  endtask

  task automatic sweep_banks();
    for (int b = 0; b < NB; b++) begin
      for (int w = 0; w < WORDS; w++) begin
        read_expect(bank_addr(b, w, 0), ref_mem[b][w], axil_map_pkg::RESP_OKAY);
      end
    end
  endtask

  task automatic run_config_tests();
    logic [DW-1:0] data;
    logic [3:0]    strb;
    logic [1:0]    resp;
    int            idx;
    for (int i = 0; i < 24; i++) begin
      data = $urandom;
      strb = $urandom_range(0, 15);
      write_expect(reg_addr(axil_map_pkg::REG_CONFIG, $urandom_range(0, 3)), data, strb,
                   axil_map_pkg::RESP_OKAY);
      ref_cfg = merge_bytes(ref_cfg, data, strb);
      check_cfg("cfg_data", ref_cfg, cfg_data);
      read_expect(reg_addr(axil_map_pkg::REG_CONFIG, 0), ref_cfg, axil_map_pkg::RESP_OKAY);
    end
    // Unknown indexes answer SLVERR and touch nothing
    for (int i = 0; i < 16; i++) begin
      idx = $urandom_range(2, 255);
      if ($urandom_range(0, 1)) begin
        write_expect(reg_addr(idx, 0), $urandom, 4'hf, axil_map_pkg::RESP_SLVERR);
      end else begin
        axi_read(reg_addr(idx, 0), data, resp);
        check_resp("rresp", axil_map_pkg::RESP_SLVERR, resp);
      end
      check_cfg("cfg_data", ref_cfg, cfg_data);
    end
    read_expect(reg_addr(axil_map_pkg::REG_CONFIG, 0), ref_cfg, axil_map_pkg::RESP_OKAY);
    expect_status();
  endtask

  task automatic pulse_done();
    ap_done = 1'b1;
    @(posedge aclk);
    #1;
    ap_done  = 1'b0;
    ref_done = 1'b1;
  endtask

  task automatic run_done_tests();
    expect_status();
    pulse_done();
    expect_status();
    // Neither zero data nor a one with lane 0 off clears it
    write_expect(reg_addr(axil_map_pkg::REG_STATUS, 0), 32'h0, 4'hf, axil_map_pkg::RESP_OKAY);
    expect_status();
    write_expect(reg_addr(axil_map_pkg::REG_STATUS, 0), 32'hffff_ffff, 4'b1110,
                 axil_map_pkg::RESP_OKAY);
    expect_status();
    write_expect(reg_addr(axil_map_pkg::REG_STATUS, 0), 32'h1, 4'b0001,
                 axil_map_pkg::RESP_OKAY);
    ref_done = 1'b0;
    expect_status();
    // Set again so later phases see a live done bit
    pulse_done();
    expect_status();
  endtask

  task automatic run_unmapped_tests();
    logic [1:0] region;
    logic [9:0] low;
    for (int i = 0; i < 24; i++) begin
      region = $urandom_range(2, 3);
      low    = $urandom;
      if ($urandom_range(0, 1)) begin
        write_expect({region, low}, $urandom, $urandom_range(0, 15),
                     axil_map_pkg::RESP_DECERR);
      end else begin
        read_expect({region, low}, '0, axil_map_pkg::RESP_DECERR);
      end
    end
    check_cfg("cfg_data", ref_cfg, cfg_data);
    expect_status();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h2fe2));
    aclk       = 1'b0;
    aresetn    = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    ap_done    = 1'b0;
    bram_rdata <= '0;
    ref_cfg    = '0;
    ref_done   = 1'b0;
    for (int b = 0; b < NB; b++) begin
      for (int w = 0; w < WORDS; w++) begin
        bank_mem[b][w] <= fill_word(b, w);
        ref_mem[b][w]  = fill_word(b, w);
      end
    end

    repeat (3) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    check_reset_state();
    run_done_tests();
    run_bank_traffic(400);
    run_config_tests();
    run_unmapped_tests();
    // Full sweep catches stray writes from earlier phases
    sweep_banks();

    $display("Test completed successfully");
    $finish;
  end

endmodule

/* build.f */
+incdir+verif
hw/axil_map_pkg.sv
hw/axil_front.sv
hw/axil_addr_decode.sv
hw/bank_port.sv
hw/ctrl_regs.sv
hw/rsp_collect.sv
hw/axil_bram_subsys.sv
verif/tb_axil_bram_subsys.sv

/* Bender.yml */
package:
  name: axil_bram_subsys

sources:
  - files:
      - hw/axil_map_pkg.sv
      - hw/axil_front.sv
      - hw/axil_addr_decode.sv
      - hw/bank_port.sv
      - hw/ctrl_regs.sv
      - hw/rsp_collect.sv
      - hw/axil_bram_subsys.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_axil_bram_subsys.sv
